//--- flash_pkg.sv
package flash_pkg;

	// sizes shrunk for simulation
	localparam int FLASH_ADDR_W     = 24;
	localparam int SRAM_ADDR_W      = 18;
	localparam int SRAM_DATA_W      = 16;
	localparam int PAGE_BYTES       = 16;
	localparam int REGION_PAGES     = 4;
	localparam int SPI_CLK_DIV      = 4;
	localparam int FRAME_GAP_CYCLES = 8;
	localparam int SETTLE_CYCLES    = 400;

	// region table, one sector per region
	localparam logic [FLASH_ADDR_W-1:0] PARAM_FLASH_BASE = 24'h0A0000;
	localparam logic [SRAM_ADDR_W-1:0]  PARAM_SRAM_BASE  = 18'h00000;
	localparam logic [FLASH_ADDR_W-1:0] CAL_FLASH_BASE   = 24'h0C0000;
	localparam logic [SRAM_ADDR_W-1:0]  CAL_SRAM_BASE    = 18'h10000;

	typedef enum logic [7:0] {
		OP_PAGE_PROG    = 8'h02,
		OP_READ         = 8'h03,
		OP_WRITE_EN     = 8'h06,
		OP_SECTOR_ERASE = 8'hD8
	} flash_op_e;

	typedef enum logic [3:0] {
		SEQ_BOOT,
		SEQ_IDLE,
		SEQ_WREN_E,
		SEQ_ERASE,
		SEQ_WREN_P,
		SEQ_PROG,
		SEQ_SETTLE,
		SEQ_READ,
		SEQ_DONE
	} seq_state_e;

	typedef enum logic {
		REGION_PARAM,
		REGION_CAL
	} region_e;

	typedef struct packed {
		flash_op_e               op;
		logic [FLASH_ADDR_W-1:0] addr;
		logic [7:0]              len;
	} spi_cmd_t;

	// strobes are active low, cs_en active high
	typedef struct packed {
		logic                   cs_en;
		logic                   wr_n;
		logic                   rd_n;
		logic [SRAM_ADDR_W-1:0] addr;
		logic [SRAM_DATA_W-1:0] wdata;
	} sram_bus_t;

	typedef struct packed {
		logic cs_n;
		logic sclk;
		logic mosi;
	} spi_pins_t;

endpackage

//--- spi_flash_master.sv
`timescale 1ns/100ps

module spi_flash_master (
	input  logic                 i_clk_50m,
	input  logic                 i_rst_n,
	input  logic                 i_cmd_start,
	input  flash_pkg::spi_cmd_t  i_cmd,
	output logic                 o_cmd_done,
	output logic                 o_byte_req,
	output logic                 o_rx_valid,
	output logic [7:0]           o_rx_byte,
	input  logic [7:0]           i_tx_byte,
	output flash_pkg::spi_pins_t o_spi,
	input  logic                 i_miso
);
	import flash_pkg::*;

	spi_cmd_t                            r_cmd;
	logic                                r_busy;
	logic                                r_gap_run;
	logic [$clog2(FRAME_GAP_CYCLES)-1:0] r_gap;
	logic [$clog2(SPI_CLK_DIV)-1:0]      r_div;
	logic                                r_sclk;
	logic                                r_cs_n;
	logic [2:0]                          r_bit;
	logic [7:0]                          r_idx;
	logic [7:0]                          r_tx_sh;
	logic [7:0]                          r_rx_sh;
	logic [7:0]                          r_tx_next;
	logic                                w_start;
	logic                                w_tick;
	logic                                w_rise;
	logic                                w_fall;
	logic                                w_end_byte;
	logic [7:0]                          w_hdr;
	logic [7:0]                          w_last;
	logic [7:0]                          w_next_idx;
	logic [7:0]                          w_next_byte;

	// opcode plus three address bytes, write enable has none
	function automatic logic [7:0] hdr_len(input flash_op_e op);
		return (op == OP_WRITE_EN) ? 8'd1 : 8'd4;
	endfunction

	assign w_start    = i_cmd_start && !r_busy && !r_gap_run;
	assign w_tick     = r_busy && (r_div == SPI_CLK_DIV - 1);
	assign w_rise     = w_tick && !r_sclk;
	assign w_fall     = w_tick && r_sclk;
	assign w_end_byte = w_fall && (r_bit == 3'd7);
	assign w_hdr      = hdr_len(r_cmd.op);
	assign w_last     = w_hdr + r_cmd.len - 8'd1;
	assign w_next_idx = r_idx + 8'd1;

	always_comb begin
		if (w_next_idx >= w_hdr)
			w_next_byte = r_tx_next;
		else if (w_next_idx == 8'd1)
			w_next_byte = r_cmd.addr[23:16];
		else if (w_next_idx == 8'd2)
			w_next_byte = r_cmd.addr[15:8];
		else
			w_next_byte = r_cmd.addr[7:0];
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_busy     <= 1'b0;
			r_gap_run  <= 1'b0;
			r_gap      <= '0;
			r_div      <= '0;
			r_sclk     <= 1'b0;
			r_cs_n     <= 1'b1;
			r_bit      <= '0;
			r_idx      <= '0;
			o_cmd_done <= 1'b0;
			o_byte_req <= 1'b0;
			o_rx_valid <= 1'b0;
		end else begin
			o_cmd_done <= 1'b0;
			o_byte_req <= 1'b0;
			o_rx_valid <= 1'b0;
			if (w_start) begin
				r_busy     <= 1'b1;
				r_cs_n     <= 1'b0;
				r_div      <= '0;
				r_bit      <= '0;
				r_idx      <= '0;
				o_byte_req <= (hdr_len(i_cmd.op) == 8'd1) && (i_cmd.len != 8'd0);
			end else if (r_busy) begin
				r_div <= w_tick ? '0 : r_div + 1'b1;
				if (w_tick)
					r_sclk <= !r_sclk;
				if (w_fall)
					r_bit <= r_bit + 3'd1;
				if (w_end_byte) begin
					if (r_idx == w_last) begin
						r_busy    <= 1'b0;
						r_cs_n    <= 1'b1;
						r_gap_run <= 1'b1;
						r_gap     <= '0;
					end else begin
						r_idx      <= w_next_idx;
						// ask one byte ahead for the following data byte
						o_byte_req <= (w_next_idx + 8'd1 >= w_hdr) && (w_next_idx + 8'd1 <= w_last);
					end
					if (r_cmd.op == OP_READ && r_idx >= w_hdr)
						o_rx_valid <= 1'b1;
				end
			end else if (r_gap_run) begin
				r_gap <= r_gap + 1'b1;
				if (r_gap == FRAME_GAP_CYCLES - 1) begin
					r_gap_run  <= 1'b0;
					o_cmd_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (w_start) begin
			r_cmd   <= i_cmd;
			r_tx_sh <= i_cmd.op;
		end else if (w_end_byte) begin
			r_tx_sh <= w_next_byte;
		end else if (w_fall) begin
			r_tx_sh <= {r_tx_sh[6:0], 1'b0};
		end
		// mode 0, sample on rising edge
		if (w_rise)
			r_rx_sh <= {r_rx_sh[6:0], i_miso};
		if (o_byte_req)
			r_tx_next <= i_tx_byte;
		if (w_end_byte)
			o_rx_byte <= r_rx_sh;
	end

	assign o_spi.cs_n = r_cs_n;
	assign o_spi.sclk = r_sclk;
	assign o_spi.mosi = r_tx_sh[7] & ~r_cs_n;

endmodule

//--- sram_word_bridge.sv
`timescale 1ns/100ps

module sram_word_bridge (
	input  logic                              i_clk_50m,
	input  logic                              i_rst_n,
	input  logic                              i_load,
	input  logic [flash_pkg::SRAM_ADDR_W-1:0] i_base,
	input  logic                              i_to_sram,
	input  logic                              i_rx_valid,
	input  logic [7:0]                        i_rx_byte,
	input  logic                              i_byte_req,
	output logic [7:0]                        o_tx_byte,
	input  logic [flash_pkg::SRAM_DATA_W-1:0] i_sram_rdata,
	output flash_pkg::sram_bus_t              o_sram,
	input  logic                              i_active
);
	import flash_pkg::*;

	logic [SRAM_ADDR_W-1:0] r_addr;
	logic [SRAM_DATA_W-1:0] r_word;
	// next byte is the low half of r_word
	logic                   r_lo;
	logic                   r_wr_n;
	logic                   r_rd_n;
	logic                   r_rd_cap;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_addr   <= '0;
			r_lo     <= 1'b0;
			r_wr_n   <= 1'b1;
			r_rd_n   <= 1'b1;
			r_rd_cap <= 1'b0;
		end else begin
			r_wr_n   <= 1'b1;
			r_rd_n   <= 1'b1;
			r_rd_cap <= !r_rd_n;
			if (i_load) begin
				r_addr <= i_base;
				r_lo   <= 1'b0;
				// prefetch first word when programming
				r_rd_n <= i_to_sram;
			end else begin
				if (!r_wr_n || !r_rd_n)
					r_addr <= r_addr + 1'b1;
				if (i_to_sram && i_rx_valid) begin
					r_lo   <= !r_lo;
					r_wr_n <= !r_lo;
				end else if (!i_to_sram && i_byte_req) begin
					r_lo   <= !r_lo;
					r_rd_n <= !r_lo;
				end
			end
		end
	end

	// shared between packer and prefetch
	always_ff @(posedge i_clk_50m) begin
		if (r_rd_cap) begin
			r_word <= i_sram_rdata;
		end else if (i_to_sram && i_rx_valid) begin
			if (r_lo)
				r_word[7:0] <= i_rx_byte;
			else
				r_word[15:8] <= i_rx_byte;
		end
	end

	assign o_tx_byte    = r_lo ? r_word[7:0] : r_word[15:8];

	assign o_sram.cs_en = i_active;
	assign o_sram.wr_n  = r_wr_n;
	assign o_sram.rd_n  = r_rd_n;
	assign o_sram.addr  = r_addr;
	assign o_sram.wdata = r_word;

endmodule

//--- flash_copy_sequencer.sv
`timescale 1ns/100ps

module flash_copy_sequencer (
	input  logic                              i_clk_50m,
	input  logic                              i_rst_n,
	input  logic                              i_param_save,
	input  logic                              i_cal_save,
	output logic                              o_cmd_start,
	output flash_pkg::spi_cmd_t               o_cmd,
	input  logic                              i_cmd_done,
	output logic                              o_load,
	output logic [flash_pkg::SRAM_ADDR_W-1:0] o_base,
	output logic                              o_to_sram,
	output logic                              o_active,
	output logic                              o_read_complete
);
	import flash_pkg::*;

	seq_state_e                       r_state;
	region_e                          r_region;
	logic                             r_boot;
	logic                             r_active;
	logic [$clog2(REGION_PAGES)-1:0]  r_page;
	logic [$clog2(SETTLE_CYCLES)-1:0] r_settle;
	logic                             w_last_page;
	region_e                          w_save_region;

	function automatic logic [FLASH_ADDR_W-1:0] flash_base(input region_e region);
		return (region == REGION_CAL) ? CAL_FLASH_BASE : PARAM_FLASH_BASE;
	endfunction

	function automatic logic [SRAM_ADDR_W-1:0] sram_base(input region_e region);
		return (region == REGION_CAL) ? CAL_SRAM_BASE : PARAM_SRAM_BASE;
	endfunction

	assign w_last_page   = (r_page == REGION_PAGES - 1);
	// param save wins a tie
	assign w_save_region = i_param_save ? REGION_PARAM : REGION_CAL;
	assign o_active      = r_active;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state         <= SEQ_BOOT;
			r_region        <= REGION_PARAM;
			r_boot          <= 1'b1;
			r_active        <= 1'b0;
			r_page          <= '0;
			r_settle        <= '0;
			o_cmd_start     <= 1'b0;
			o_cmd           <= '{op: OP_READ, addr: '0, len: '0};
			o_load          <= 1'b0;
			o_base          <= '0;
			o_to_sram       <= 1'b1;
			o_read_complete <= 1'b0;
		end else begin
			o_cmd_start     <= 1'b0;
			o_load          <= 1'b0;
			o_read_complete <= 1'b0;
			case (r_state)
				// start of a region copy, flash to sram
				SEQ_BOOT: begin
					r_active    <= 1'b1;
					r_page      <= '0;
					o_load      <= 1'b1;
					o_base      <= sram_base(r_region);
					o_to_sram   <= 1'b1;
					o_cmd       <= '{op: OP_READ, addr: flash_base(r_region), len: 8'(PAGE_BYTES)};
					o_cmd_start <= 1'b1;
					r_state     <= SEQ_READ;
				end
				SEQ_IDLE: begin
					if (i_param_save || i_cal_save) begin
						r_region    <= w_save_region;
						r_active    <= 1'b1;
						r_page      <= '0;
						o_load      <= 1'b1;
						o_base      <= sram_base(w_save_region);
						o_to_sram   <= 1'b0;
						o_cmd       <= '{op: OP_WRITE_EN, addr: flash_base(w_save_region), len: 8'd0};
						o_cmd_start <= 1'b1;
						r_state     <= SEQ_WREN_E;
					end
				end
				SEQ_WREN_E: begin
					if (i_cmd_done) begin
						o_cmd.op    <= OP_SECTOR_ERASE;
						o_cmd_start <= 1'b1;
						r_state     <= SEQ_ERASE;
					end
				end
				SEQ_ERASE: begin
					if (i_cmd_done) begin
						o_cmd.op    <= OP_WRITE_EN;
						o_cmd_start <= 1'b1;
						r_state     <= SEQ_WREN_P;
					end
				end
				SEQ_WREN_P: begin
					if (i_cmd_done) begin
						o_cmd.op    <= OP_PAGE_PROG;
						o_cmd.len   <= 8'(PAGE_BYTES);
						o_cmd_start <= 1'b1;
						r_state     <= SEQ_PROG;
					end
				end
				SEQ_PROG: begin
					if (i_cmd_done) begin
						if (w_last_page) begin
							r_settle <= '0;
							r_state  <= SEQ_SETTLE;
						end else begin
							r_page      <= r_page + 1'b1;
							o_cmd.op    <= OP_WRITE_EN;
							o_cmd.addr  <= o_cmd.addr + FLASH_ADDR_W'(PAGE_BYTES);
							o_cmd.len   <= 8'd0;
							o_cmd_start <= 1'b1;
							r_state     <= SEQ_WREN_P;
						end
					end
				end
				SEQ_SETTLE: begin
					r_settle <= r_settle + 1'b1;
					// then reload what was just saved
					if (r_settle == SETTLE_CYCLES - 1)
						r_state <= SEQ_BOOT;
				end
				SEQ_READ: begin
					if (i_cmd_done) begin
						if (!w_last_page) begin
							r_page      <= r_page + 1'b1;
							o_cmd.addr  <= o_cmd.addr + FLASH_ADDR_W'(PAGE_BYTES);
							o_cmd_start <= 1'b1;
						end else if (r_boot && r_region == REGION_PARAM) begin
							r_region <= REGION_CAL;
							r_state  <= SEQ_BOOT;
						end else begin
							r_state <= SEQ_DONE;
						end
					end
				end
				SEQ_DONE: begin
					o_read_complete <= 1'b1;
					r_active        <= 1'b0;
					r_boot          <= 1'b0;
					r_state         <= SEQ_IDLE;
				end
				default: begin
					r_state <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

//--- flash_control.sv
`timescale 1ns/100ps

module flash_control (
	input  logic                              i_clk_50m,
	input  logic                              i_rst_n,
	input  logic                              i_param_save,
	input  logic                              i_cal_save,
	output logic                              o_flash_cs,
	output logic                              o_flash_sclk,
	output logic                              o_flash_mosi,
	input  logic                              i_flash_miso,
	output flash_pkg::sram_bus_t              o_sram,
	input  logic [flash_pkg::SRAM_DATA_W-1:0] i_sram_rdata,
	output logic                              o_read_complete
);
	import flash_pkg::*;

	spi_cmd_t               w_cmd;
	spi_pins_t              w_spi;
	logic                   w_cmd_start;
	logic                   w_cmd_done;
	logic                   w_byte_req;
	logic                   w_rx_valid;
	logic [7:0]             w_rx_byte;
	logic [7:0]             w_tx_byte;
	logic                   w_load;
	logic [SRAM_ADDR_W-1:0] w_base;
	logic                   w_to_sram;
	logic                   w_active;

	flash_copy_sequencer u_seq (
		.i_clk_50m       (i_clk_50m),
		.i_rst_n         (i_rst_n),
		.i_param_save    (i_param_save),
		.i_cal_save      (i_cal_save),
		.o_cmd_start     (w_cmd_start),
		.o_cmd           (w_cmd),
		.i_cmd_done      (w_cmd_done),
		.o_load          (w_load),
		.o_base          (w_base),
		.o_to_sram       (w_to_sram),
		.o_active        (w_active),
		.o_read_complete (o_read_complete)
	);

	spi_flash_master u_spi (
		.i_clk_50m   (i_clk_50m),
		.i_rst_n     (i_rst_n),
		.i_cmd_start (w_cmd_start),
		.i_cmd       (w_cmd),
		.o_cmd_done  (w_cmd_done),
		.o_byte_req  (w_byte_req),
		.o_rx_valid  (w_rx_valid),
		.o_rx_byte   (w_rx_byte),
		.i_tx_byte   (w_tx_byte),
		.o_spi       (w_spi),
		.i_miso      (i_flash_miso)
	);

	sram_word_bridge u_bridge (
		.i_clk_50m    (i_clk_50m),
		.i_rst_n      (i_rst_n),
		.i_load       (w_load),
		.i_base       (w_base),
		.i_to_sram    (w_to_sram),
		.i_rx_valid   (w_rx_valid),
		.i_rx_byte    (w_rx_byte),
		.i_byte_req   (w_byte_req),
		.o_tx_byte    (w_tx_byte),
		.i_sram_rdata (i_sram_rdata),
		.o_sram       (o_sram),
		.i_active     (w_active)
	);

	// spi clock goes out as a plain pin
	assign o_flash_cs   = w_spi.cs_n;
	assign o_flash_sclk = w_spi.sclk;
	assign o_flash_mosi = w_spi.mosi;

endmodule

//--- spi_flash_model.sv
`timescale 1ns/100ps

module spi_flash_model (
	input  logic i_cs_n,
	input  logic i_sclk,
	input  logic i_mosi,
	output logic o_miso
);
	import flash_pkg::*;

	// 1 MB window covers both regions
	logic [7:0]  mem [0:20'hFFFFF];
	logic [7:0]  r_op;
	logic [7:0]  r_in;
	logic [7:0]  r_out;
	logic [23:0] r_addr;
	logic        r_wel;
	int          r_bits;
	int          erase_count;

	task automatic erase_sector(input logic [23:0] addr);
		for (int i = 0; i < 65536; i++)
			mem[{addr[19:16], 16'(i)}] = 8'hFF;
	endtask

	initial begin
		r_op        = 8'h00;
		r_in        = 8'h00;
		r_out       = 8'hFF;
		r_addr      = '0;
		r_wel       = 1'b0;
		r_bits      = 0;
		erase_count = 0;
		o_miso      = 1'b0;
	end

	always @(negedge i_cs_n) begin
		r_bits = 0;
		r_op   = 8'h00;
	end

	always @(posedge i_sclk) begin
		if (!i_cs_n) begin
			r_in   = {r_in[6:0], i_mosi};
			r_bits = r_bits + 1;
			if (r_bits == 8) begin
				r_op = r_in;
			end else if (r_bits <= 32 && r_bits % 8 == 0) begin
				r_addr = {r_addr[15:0], r_in};
			end else if (r_bits % 8 == 0 && r_op == OP_PAGE_PROG && r_wel) begin
				// programming only clears bits
				mem[r_addr[19:0]] = mem[r_addr[19:0]] & r_in;
				r_addr = r_addr + 24'd1;
			end
		end
	end

	// mode 0, next bit goes out on the falling edge
	always @(negedge i_sclk) begin
		if (!i_cs_n && r_op == OP_READ && r_bits >= 32) begin
			if (r_bits % 8 == 0) begin
				r_out  = mem[r_addr[19:0]];
				r_addr = r_addr + 24'd1;
			end else begin
				r_out = {r_out[6:0], 1'b1};
			end
			o_miso = r_out[7];
		end
	end

	always @(posedge i_cs_n) begin
		if (r_op == OP_WRITE_EN && r_bits == 8) begin
			r_wel = 1'b1;
		end else if (r_op == OP_SECTOR_ERASE && r_bits == 32 && r_wel) begin
			erase_sector(r_addr);
			erase_count = erase_count + 1;
			r_wel       = 1'b0;
		end else if (r_op == OP_PAGE_PROG) begin
			r_wel = 1'b0;
		end
	end

endmodule

//--- tb_monitor.sv
`timescale 1ns/100ps

module tb_monitor (
	input  logic                 i_clk_50m,
	input  logic                 i_rst_n,
	input  logic                 i_param_save,
	input  logic                 i_cal_save,
	input  logic                 i_flash_cs,
	input  logic                 i_flash_sclk,
	input  flash_pkg::sram_bus_t i_sram,
	input  logic                 i_read_complete,
	output int                   o_errors,
	output int                   o_checks
);
	import flash_pkg::*;

	// byte image of each region as the flash should hold it
	logic [7:0] img [0:1][0:REGION_PAGES*PAGE_BYTES-1];
	logic       r_prev_rst_n;
	logic       r_clocked;
	logic       busy;
	logic       boot;
	int         region;
	int         word_idx;
	int         writes;
	int         saves;

	// first byte of each pair is the high half
	function automatic logic [15:0] expected_word(input int r, input int idx);
		return {img[r][2*idx], img[r][2*idx+1]};
	endfunction

	function automatic logic [23:0] flash_base(input int r);
		return (r == 1) ? CAL_FLASH_BASE : PARAM_FLASH_BASE;
	endfunction

	function automatic logic [17:0] sram_base(input int r);
		return (r == 1) ? CAL_SRAM_BASE : PARAM_SRAM_BASE;
	endfunction

	function automatic logic [7:0] flash_byte(input logic [23:0] a);
		return tb_flash_control.u_flash.mem[a[19:0]];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		o_checks++;
		if (got !== exp) begin
			o_errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_problem(input string what);
		o_errors++;
		$display("ERROR: %s", what);
	endtask

	task automatic check_flash();
		for (int r = 0; r < 2; r++)
			for (int i = 0; i < REGION_PAGES * PAGE_BYTES; i++)
				check_value("flash byte", flash_byte(flash_base(r) + 24'(i)), img[r][i]);
		check_value("erase count", tb_flash_control.u_flash.erase_count, saves);
	endtask

	task automatic start_boot();
		busy     = 1'b1;
		boot     = 1'b1;
		region   = 0;
		word_idx = 0;
		writes   = 0;
		for (int r = 0; r < 2; r++)
			for (int i = 0; i < REGION_PAGES * PAGE_BYTES; i++)
				img[r][i] = flash_byte(flash_base(r) + 24'(i));
	endtask

	task automatic start_save(input int r);
		logic [15:0] word;
		saves++;
		busy     = 1'b1;
		boot     = 1'b0;
		region   = r;
		word_idx = 0;
		writes   = 0;
		for (int i = 0; i < REGION_PAGES * PAGE_BYTES / 2; i++) begin
			word           = tb_flash_control.sram_mem[sram_base(r) + 18'(i)];
			img[r][2*i]    = word[15:8];
			img[r][2*i+1]  = word[7:0];
		end
	endtask

	task automatic check_write();
		if (!busy) begin
			report_problem("SRAM write while no copy is running");
		end else begin
			check_value("sram addr", i_sram.addr, sram_base(region) + 18'(word_idx));
			check_value("sram wdata", i_sram.wdata, expected_word(region, word_idx));
			check_value("sram cs_en", i_sram.cs_en, 1'b1);
			writes++;
			word_idx++;
			// boot moves on to the calibration region
			if (boot && word_idx == REGION_PAGES * PAGE_BYTES / 2 && region == 0) begin
				region   = 1;
				word_idx = 0;
			end
		end
	endtask

	task automatic finish_copy();
		if (!busy) begin
			report_problem("read-complete pulse while no copy is running");
		end else begin
			check_value("sram write count", writes,
				boot ? REGION_PAGES * PAGE_BYTES : REGION_PAGES * PAGE_BYTES / 2);
			check_flash();
			busy = 1'b0;
		end
	endtask

	initial begin
		o_errors     = 0;
		o_checks     = 0;
		r_prev_rst_n = 1'b0;
		r_clocked    = 1'b0;
		busy         = 1'b0;
		boot         = 1'b0;
		saves        = 0;
	end

	always @(posedge i_clk_50m) begin
		// outputs are defined once reset has seen a clock edge
		if (r_clocked && (!i_rst_n || !r_prev_rst_n)) begin
			check_value("o_flash_cs", i_flash_cs, 1'b1);
			check_value("o_flash_sclk", i_flash_sclk, 1'b0);
			check_value("sram wr_n", i_sram.wr_n, 1'b1);
			check_value("sram rd_n", i_sram.rd_n, 1'b1);
			check_value("sram cs_en", i_sram.cs_en, 1'b0);
			check_value("o_read_complete", i_read_complete, 1'b0);
		end
		if (i_rst_n && !r_prev_rst_n)
			start_boot();
		if (i_rst_n && r_prev_rst_n) begin
			if (!i_sram.wr_n)
				check_write();
			if (i_read_complete)
				finish_copy();
			// param save wins a tie
			if (!busy && (i_param_save || i_cal_save))
				start_save(i_param_save ? 0 : 1);
		end
		r_prev_rst_n <= i_rst_n;
		r_clocked    <= 1'b1;
	end

endmodule

//--- flash_control_checker.sv
`timescale 1ns/100ps

module flash_control_checker (
	input logic                 i_clk_50m,
	input logic                 i_rst_n,
	input logic                 i_cs_n,
	input logic                 i_sclk,
	input logic                 i_cmd_done,
	input flash_pkg::sram_bus_t i_sram
);
	int assert_errors = 0;

	// spi clock parks low between frames
	a_sclk_idle: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_cs_n |-> !i_sclk)
		else begin
			$error("spi clock active with chip select high");
			assert_errors++;
		end

	a_done_gap: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		i_cmd_done |-> i_cs_n)
		else begin
			$error("command done raised inside a frame");
			assert_errors++;
		end

	a_sram_strobes: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		!(!i_sram.wr_n && !i_sram.rd_n))
		else begin
			$error("sram wr_n and rd_n low together");
			assert_errors++;
		end

endmodule

bind flash_control flash_control_checker u_chk (
	.i_clk_50m  (i_clk_50m),
	.i_rst_n    (i_rst_n),
	.i_cs_n     (o_flash_cs),
	.i_sclk     (o_flash_sclk),
	.i_cmd_done (w_cmd_done),
	.i_sram     (o_sram)
);

//--- tb_flash_control.sv
`timescale 1ns/100ps

module tb_flash_control;
	import flash_pkg::*;

	logic                   clk_50m;
	logic                   rst_n;
	logic                   param_save;
	logic                   cal_save;
	logic                   flash_cs;
	logic                   flash_sclk;
	logic                   flash_mosi;
	logic                   flash_miso;
	sram_bus_t              sram_bus;
	logic [SRAM_DATA_W-1:0] sram_rdata;
	logic                   read_complete;
	logic [SRAM_DATA_W-1:0] sram_mem [0:2**SRAM_ADDR_W-1];
	int                     seed;
	int                     err_mark;
	int                     mon_errors;
	int                     mon_checks;
	int                     cycles;
	int                     cycle_limit;

	flash_control u_dut (
		.i_clk_50m       (clk_50m),
		.i_rst_n         (rst_n),
		.i_param_save    (param_save),
		.i_cal_save      (cal_save),
		.o_flash_cs      (flash_cs),
		.o_flash_sclk    (flash_sclk),
		.o_flash_mosi    (flash_mosi),
		.i_flash_miso    (flash_miso),
		.o_sram          (sram_bus),
		.i_sram_rdata    (sram_rdata),
		.o_read_complete (read_complete)
	);

	spi_flash_model u_flash (
		.i_cs_n (flash_cs),
		.i_sclk (flash_sclk),
		.i_mosi (flash_mosi),
		.o_miso (flash_miso)
	);

	tb_monitor u_mon (
		.i_clk_50m       (clk_50m),
		.i_rst_n         (rst_n),
		.i_param_save    (param_save),
		.i_cal_save      (cal_save),
		.i_flash_cs      (flash_cs),
		.i_flash_sclk    (flash_sclk),
		.i_sram          (sram_bus),
		.i_read_complete (read_complete),
		.o_errors        (mon_errors),
		.o_checks        (mon_checks)
	);

	initial begin
		clk_50m = 1'b0;
		forever #10 clk_50m = ~clk_50m;
	end

	// sram model, read data one cycle after rd_n
	always @(posedge clk_50m) begin
		if (sram_bus.cs_en && !sram_bus.wr_n)
			sram_mem[sram_bus.addr] <= sram_bus.wdata;
		if (!sram_bus.rd_n)
			sram_rdata <= sram_mem[sram_bus.addr];
	end

	function automatic int frame_cycles(input int nbytes);
		return nbytes * 16 * SPI_CLK_DIV + FRAME_GAP_CYCLES + 4;
	endfunction

	// boot, idle wait, two saves with reload, plus half again
	function automatic int run_limit();
		int page_read;
		int boot;
		int save;
		page_read = frame_cycles(4 + PAGE_BYTES);
		boot      = 2 * REGION_PAGES * page_read;
		save      = frame_cycles(1) + frame_cycles(4) + SETTLE_CYCLES
			+ REGION_PAGES * (frame_cycles(1) + 2 * page_read);
		return (boot + SETTLE_CYCLES + 2 * save) * 3 / 2 + 16;
	endfunction

	function automatic int total_errors();
		return mon_errors + u_dut.u_chk.assert_errors;
	endfunction

	task automatic preload_flash();
		u_flash.erase_sector(PARAM_FLASH_BASE);
		u_flash.erase_sector(CAL_FLASH_BASE);
		for (int i = 0; i < REGION_PAGES * PAGE_BYTES; i++) begin
			u_flash.mem[PARAM_FLASH_BASE[19:0] + 20'(i)] = 8'($random(seed));
			u_flash.mem[CAL_FLASH_BASE[19:0] + 20'(i)]   = 8'($random(seed));
		end
	endtask

	task automatic fill_sram(input logic [SRAM_ADDR_W-1:0] base);
		for (int i = 0; i < REGION_PAGES * PAGE_BYTES / 2; i++)
			sram_mem[base + SRAM_ADDR_W'(i)] = 16'($random(seed));
	endtask

	task automatic wait_read_complete();
		@(posedge clk_50m);
		while (!read_complete)
			@(posedge clk_50m);
	endtask

	task automatic run_save(input region_e region);
		fill_sram((region == REGION_CAL) ? CAL_SRAM_BASE : PARAM_SRAM_BASE);
		@(posedge clk_50m);
		if (region == REGION_CAL)
			cal_save <= 1'b1;
		else
			param_save <= 1'b1;
		@(posedge clk_50m);
		param_save <= 1'b0;
		cal_save   <= 1'b0;
		wait_read_complete();
	endtask

	task automatic report_test(input string name);
		int errs;
		errs = total_errors() - err_mark;
		if (errs == 0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errs);
		err_mark = total_errors();
	endtask

	initial begin
		cycle_limit = run_limit();
		cycles      = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk_50m);
			cycles++;
		end
		$display("timeout: tests did not finish within %0d cycles", cycle_limit);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		seed       = 92222;
		err_mark   = 0;
		rst_n      = 1'b0;
		param_save = 1'b0;
		cal_save   = 1'b0;
		sram_rdata = '0;
		preload_flash();
		repeat (8) @(posedge clk_50m);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_50m);
		report_test("reset");

		// strobe in the middle of the boot copy
		repeat (2000) @(posedge clk_50m);
		param_save <= 1'b1;
		cal_save   <= 1'b1;
		@(posedge clk_50m);
		param_save <= 1'b0;
		cal_save   <= 1'b0;
		wait_read_complete();
		report_test("boot load");

		repeat (SETTLE_CYCLES) @(posedge clk_50m);
		u_mon.check_flash();
		report_test("ignored save request");

		run_save(REGION_PARAM);
		report_test("parameter save");
		run_save(REGION_CAL);
		report_test("calibration save");

		$display("tests: 5, checks: %0d, errors: %0d", mon_checks, total_errors());
		if (total_errors() == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- list.f
flash_pkg.sv
spi_flash_master.sv
sram_word_bridge.sv
flash_copy_sequencer.sv
flash_control.sv
spi_flash_model.sv
tb_monitor.sv
flash_control_checker.sv
tb_flash_control.sv
